/* flist.f */
+incdir+src
src/pipe_pkg.sv
src/cp0_pkg.sv
src/reg_file.sv
src/cp0_regs.sv
src/wb_stage.sv
src/wb_top.sv
testbench/tb_wb_top.sv

/* Bender.yml */
package:
  name: wb_top

export_include_dirs:
  - src

sources:
  - src/pipe_pkg.sv
  - src/cp0_pkg.sv
  - src/reg_file.sv
  - src/cp0_regs.sv
  - src/wb_stage.sv
  - src/wb_top.sv
  - target: test
    files:
      - testbench/tb_wb_top.sv

/* testbench/tb_wb_top.sv */
`include "wb_macros.svh"

`default_nettype none

module tb_wb_top
    import pipe_pkg::*;
    import cp0_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       reset;
    logic       ms_valid;
    word_t      ms_pc;
    word_t      ms_result;
    reg_addr_t  ms_dest;
    logic       ms_gr_we;
    logic       ms_ex;
    exc_code_t  ms_exc_code;
    logic       ms_bd;
    logic       ms_eret;
    logic       ms_mtc0;
    logic       ms_mfc0;
    cp0_addr_t  ms_cp0_addr;
    word_t      ms_badvaddr;
    logic [5:0] ext_int;
    reg_addr_t  rf_raddr1;
    reg_addr_t  rf_raddr2;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    reg_addr_t  wb_dest;
    word_t      wb_result;
    logic       flush;
    word_t      flush_target;
    logic       int_pending;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    integer seed = 95821;
    word_t  exp_epc;  // EPC as the exception rules predict it

    wb_top uut (
        .clk, .reset,
        .ms_valid, .ms_pc, .ms_result, .ms_dest, .ms_gr_we,
        .ms_ex, .ms_exc_code, .ms_bd, .ms_eret,
        .ms_mtc0, .ms_mfc0, .ms_cp0_addr, .ms_badvaddr,
        .ext_int, .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .wb_dest, .wb_result, .flush, .flush_target, .int_pending,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_flush(input int limit);
        int n;
        n = 0;
        while (flush !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (flush !== 1'b1) begin
            $display("flush did not rise within %0d cycles", limit);
            stop_run();
        end
    endtask

    task automatic wait_int(input int limit);
        int n;
        n = 0;
        while (int_pending !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (int_pending !== 1'b1) begin
            $display("int_pending did not rise within %0d cycles", limit);
            stop_run();
        end
    endtask

    // one-cycle ms_valid pulse that returns in the writeback cycle
    task automatic retire(input word_t pc, input word_t result, input reg_addr_t dest,
                          input logic gr_we, input logic ex, input exc_code_t code,
                          input logic bd, input logic eret, input logic mtc0,
                          input logic mfc0, input cp0_addr_t addr, input word_t badv);
        @(posedge clk);
        ms_valid    <= 1'b1;
        ms_pc       <= pc;
        ms_result   <= result;
        ms_dest     <= dest;
        ms_gr_we    <= gr_we;
        ms_ex       <= ex;
        ms_exc_code <= code;
        ms_bd       <= bd;
        ms_eret     <= eret;
        ms_mtc0     <= mtc0;
        ms_mfc0     <= mfc0;
        ms_cp0_addr <= addr;
        ms_badvaddr <= badv;
        @(posedge clk);
        ms_valid <= 1'b0;
        @(negedge clk);  // stable point in writeback
    endtask

    task automatic alu_write(input word_t pc, input reg_addr_t dest, input word_t data);
        retire(pc, data, dest, 1'b1, 1'b0, EXC_INT, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic mtc0_write(input cp0_addr_t addr, input word_t data);
        retire(32'hbfc0_1000, data, '0, 1'b0, 1'b0, EXC_INT, 1'b0, 1'b0, 1'b1, 1'b0, addr, '0);
    endtask

    task automatic read_check(input reg_addr_t addr, input word_t exp);
        @(posedge clk);
        rf_raddr1 <= addr;
        @(negedge clk);
        check_word("register read", rf_rdata1, exp);
    endtask

    // mfc0 into $30 and fetched back from the register file
    task automatic cp0_read(input cp0_addr_t addr, output word_t value);
        retire(32'hbfc0_2000, '0, 5'd30, 1'b1, 1'b0, EXC_INT, 1'b0, 1'b0, 1'b0, 1'b1, addr, '0);
        check_bit("mfc0 write enable", debug_wb_rf_wen == 4'hf, 1'b1);
        @(posedge clk);
        rf_raddr2 <= 5'd30;
        @(negedge clk);
        value = rf_rdata2;
    endtask

    task automatic raise_exc(input word_t pc, input exc_code_t code, input logic bd,
                             input word_t badv, input reg_addr_t dest);
        retire(pc, 32'hdead_beef, dest, 1'b1, 1'b1, code, bd, 1'b0, 1'b0, 1'b0, '0, badv);
        wait_flush(4);
        check_word("exception target", flush_target, `EXC_VECTOR);
        check_bit("write enable on exception", debug_wb_rf_wen != 4'h0, 1'b0);
        check_reg("forward dest on exception", wb_dest, '0);
    endtask

    task automatic test_alu();
        word_t     data;
        word_t     pc;
        reg_addr_t dest;
        for (int i = 0; i < 6; i++) begin
            data = $random(seed);
            dest = $random(seed);
            if (dest == '0) begin
                dest = 5'd1;
            end
            pc = 32'hbfc0_0000 + i * 4;
            alu_write(pc, dest, data);
            check_word("trace pc", debug_wb_pc, pc);
            check_bit("trace wen", debug_wb_rf_wen == 4'hf, 1'b1);
            check_reg("trace wnum", debug_wb_rf_wnum, dest);
            check_word("trace wdata", debug_wb_rf_wdata, data);
            check_reg("forward dest", wb_dest, dest);
            check_word("forward result", wb_result, data);
            read_check(dest, data);
            check_reg("forward dest when empty", wb_dest, '0);
        end
        alu_write(32'hbfc0_0040, 5'd0, 32'hffff_ffff);
        read_check(5'd0, '0);  // $0 stays zero
    endtask

    task automatic test_cp0_move();
        word_t epc_val;
        word_t v;
        epc_val = $random(seed);
        mtc0_write(CP0_EPC, epc_val);
        mtc0_write(CP0_COMPARE, 32'h7000_0000);  // far beyond Count
        mtc0_write(CP0_STATUS, 32'h0000_5a00);
        cp0_read(CP0_EPC, v);
        check_word("epc", v, epc_val);
        cp0_read(CP0_COMPARE, v);
        check_word("compare", v, 32'h7000_0000);
        cp0_read(CP0_STATUS, v);
        check_word("status.im", {24'h0, v[15:8]}, 32'h5a);
        check_bit("status.exl", v[1], 1'b0);
        check_bit("status.ie", v[0], 1'b0);
    endtask

    task automatic test_exceptions();
        word_t keep;
        word_t badv;
        word_t v;
        keep = $random(seed);
        alu_write(32'hbfc0_0100, 5'd9, keep);
        raise_exc(32'hbfc0_0104, EXC_OV, 1'b0, '0, 5'd9);
        exp_epc = 32'hbfc0_0104;
        read_check(5'd9, keep);  // squashed write
        cp0_read(CP0_EPC, v);
        check_word("epc", v, exp_epc);
        cp0_read(CP0_CAUSE, v);
        check_word("cause.exccode", {27'h0, v[6:2]}, word_t'(EXC_OV));
        check_bit("cause.bd", v[31], 1'b0);
        cp0_read(CP0_STATUS, v);
        check_bit("status.exl", v[1], 1'b1);

        mtc0_write(CP0_STATUS, 32'h0);
        badv = $random(seed);
        raise_exc(32'hbfc0_0208, EXC_ADEL, 1'b1, badv, 5'd9);
        exp_epc = 32'hbfc0_0208 - 32'd4;  // branch of the delay slot
        cp0_read(CP0_EPC, v);
        check_word("epc in delay slot", v, exp_epc);
        cp0_read(CP0_CAUSE, v);
        check_word("cause.exccode", {27'h0, v[6:2]}, word_t'(EXC_ADEL));
        check_bit("cause.bd", v[31], 1'b1);
        cp0_read(CP0_BADVADDR, v);
        check_word("badvaddr", v, badv);

        // nested exception with EXL still set
        raise_exc(32'hbfc0_0300, EXC_SYS, 1'b0, '0, 5'd9);
        cp0_read(CP0_EPC, v);
        check_word("epc after nested exception", v, exp_epc);
        cp0_read(CP0_CAUSE, v);
        check_word("cause.exccode", {27'h0, v[6:2]}, word_t'(EXC_SYS));
    endtask

    task automatic test_eret();
        word_t v;
        retire(32'hbfc0_0400, '0, '0, 1'b0, 1'b0, EXC_INT, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0);
        wait_flush(4);
        check_word("eret target", flush_target, exp_epc);
        cp0_read(CP0_STATUS, v);
        check_bit("status.exl after eret", v[1], 1'b0);
    endtask

    task automatic test_interrupts();
        word_t cnt;
        word_t v;
        mtc0_write(CP0_STATUS, 32'h0000_0401);  // IM2 and IE
        @(posedge clk);
        ext_int <= 6'b000001;
        wait_int(8);
        @(posedge clk);
        ext_int <= '0;
        @(negedge clk);
        check_bit("int_pending after release", int_pending, 1'b0);

        mtc0_write(CP0_STATUS, 32'h0000_0403);  // same with EXL set
        @(posedge clk);
        ext_int <= 6'b000001;
        repeat (4) begin
            @(negedge clk);
            check_bit("int_pending with exl", int_pending, 1'b0);
        end
        @(posedge clk);
        ext_int <= '0;

        mtc0_write(CP0_STATUS, 32'h0000_8001);  // IM7 and IE
        cp0_read(CP0_COUNT, cnt);
        mtc0_write(CP0_COMPARE, cnt + 32'd24);
        @(negedge clk);
        check_bit("int_pending before match", int_pending, 1'b0);
        wait_int(100);
        cp0_read(CP0_CAUSE, v);
        check_bit("cause.ip7", v[15], 1'b1);
        check_bit("cause.ti", v[30], 1'b1);

        mtc0_write(CP0_COMPARE, cnt + 32'h0100_0000);
        @(negedge clk);
        check_bit("int_pending after compare write", int_pending, 1'b0);
        cp0_read(CP0_CAUSE, v);
        check_bit("cause.ip7 cleared", v[15], 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        ms_valid    = 1'b0;
        ms_pc       = '0;
        ms_result   = '0;
        ms_dest     = '0;
        ms_gr_we    = 1'b0;
        ms_ex       = 1'b0;
        ms_exc_code = EXC_INT;
        ms_bd       = 1'b0;
        ms_eret     = 1'b0;
        ms_mtc0     = 1'b0;
        ms_mfc0     = 1'b0;
        ms_cp0_addr = '0;
        ms_badvaddr = '0;
        ext_int     = '0;
        rf_raddr1   = '0;
        rf_raddr2   = '0;
        exp_epc     = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("write enable after reset", debug_wb_rf_wen != 4'h0, 1'b0);
        check_bit("flush after reset", flush, 1'b0);
        check_bit("int_pending after reset", int_pending, 1'b0);
        test_alu();
        test_cp0_move();
        test_exceptions();
        test_eret();
        test_interrupts();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src/wb_top.sv */
`include "wb_macros.svh"

`default_nettype none

module wb_top
    import pipe_pkg::*;
    import cp0_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        ms_valid,
    input  word_t      ms_pc,
    input  word_t      ms_result,
    input  reg_addr_t  ms_dest,
    input  wire        ms_gr_we,
    input  wire        ms_ex,
    input  exc_code_t  ms_exc_code,
    input  wire        ms_bd,
    input  wire        ms_eret,
    input  wire        ms_mtc0,
    input  wire        ms_mfc0,
    input  cp0_addr_t  ms_cp0_addr,
    input  word_t      ms_badvaddr,
    input  wire [5:0]  ext_int,
    input  reg_addr_t  rf_raddr1,
    input  reg_addr_t  rf_raddr2,
    output word_t      rf_rdata1,
    output word_t      rf_rdata2,
    output reg_addr_t  wb_dest,
    output word_t      wb_result,
    output wire        flush,
    output word_t      flush_target,
    output wire        int_pending,
    output word_t      debug_wb_pc,
    output wire [3:0]  debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    wire       ws_valid;
    word_t     ws_pc;
    word_t     ws_result;
    wire       ws_ex;
    exc_code_t ws_exc_code;
    wire       ws_bd;
    wire       ws_eret;
    wire       ws_mtc0;
    cp0_addr_t ws_cp0_addr;
    word_t     ws_badvaddr;
    word_t     cp0_rdata;
    wire       rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    wb_stage u_wb_stage (
        .clk, .reset,
        .ms_valid, .ms_pc, .ms_result, .ms_dest, .ms_gr_we,
        .ms_ex, .ms_exc_code, .ms_bd, .ms_eret,
        .ms_mtc0, .ms_mfc0, .ms_cp0_addr, .ms_badvaddr,
        .flush, .cp0_rdata,
        .ws_valid, .ws_pc, .ws_result, .ws_ex, .ws_exc_code,
        .ws_bd, .ws_eret, .ws_mtc0, .ws_cp0_addr, .ws_badvaddr,
        .rf_we, .rf_waddr, .rf_wdata,
        .wb_dest, .wb_result,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    cp0_regs u_cp0_regs (
        .clk, .reset,
        .ws_valid, .ws_pc, .ws_result, .ws_ex, .ws_exc_code,
        .ws_bd, .ws_eret, .ws_mtc0, .ws_cp0_addr, .ws_badvaddr,
        .ext_int,
        .cp0_rdata, .flush, .flush_target, .int_pending
    );

    reg_file u_reg_file (
        .clk, .reset,
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`include "wb_macros.svh"

`default_nettype none

module wb_stage
    import pipe_pkg::*;
    import cp0_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        ms_valid,
    input  word_t      ms_pc,
    input  word_t      ms_result,
    input  reg_addr_t  ms_dest,
    input  wire        ms_gr_we,
    input  wire        ms_ex,
    input  exc_code_t  ms_exc_code,
    input  wire        ms_bd,
    input  wire        ms_eret,
    input  wire        ms_mtc0,
    input  wire        ms_mfc0,
    input  cp0_addr_t  ms_cp0_addr,
    input  word_t      ms_badvaddr,
    input  wire        flush,
    input  word_t      cp0_rdata,
    output logic       ws_valid,
    output word_t      ws_pc,
    output word_t      ws_result,
    output logic       ws_ex,
    output exc_code_t  ws_exc_code,
    output logic       ws_bd,
    output logic       ws_eret,
    output logic       ws_mtc0,
    output cp0_addr_t  ws_cp0_addr,
    output word_t      ws_badvaddr,
    output wire        rf_we,
    output reg_addr_t  rf_waddr,
    output word_t      rf_wdata,
    output reg_addr_t  wb_dest,
    output word_t      wb_result,
    output word_t      debug_wb_pc,
    output wire [3:0]  debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    reg_addr_t ws_dest;
    logic      ws_gr_we;
    logic      ws_mfc0;
    word_t     final_result;

    // stage never stalls, flush empties it
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        ws_pc       <= ms_pc;
        ws_result   <= ms_result;
        ws_dest     <= ms_dest;
        ws_gr_we    <= ms_gr_we;
        ws_ex       <= ms_ex;
        ws_exc_code <= ms_exc_code;
        ws_bd       <= ms_bd;
        ws_eret     <= ms_eret;
        ws_mtc0     <= ms_mtc0;
        ws_mfc0     <= ms_mfc0;
        ws_cp0_addr <= ms_cp0_addr;
        ws_badvaddr <= ms_badvaddr;
    end

    assign final_result = ws_mfc0 ? cp0_rdata : ws_result;

    // excepting instruction is squashed
    assign rf_we    = ws_valid & ws_gr_we & ~ws_ex;
    assign rf_waddr = ws_dest;
    assign rf_wdata = final_result;

    assign wb_dest   = rf_we ? ws_dest : '0;  // no forwarding when nothing retires
    assign wb_result = final_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

`default_nettype wire

/* src/cp0_regs.sv */
`include "wb_macros.svh"

`default_nettype none

module cp0_regs
    import pipe_pkg::*;
    import cp0_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  wire       ws_valid,
    input  word_t     ws_pc,
    input  word_t     ws_result,
    input  wire       ws_ex,
    input  exc_code_t ws_exc_code,
    input  wire       ws_bd,
    input  wire       ws_eret,
    input  wire       ws_mtc0,
    input  cp0_addr_t ws_cp0_addr,
    input  word_t     ws_badvaddr,
    input  wire [5:0] ext_int,
    output word_t     cp0_rdata,
    output wire       flush,
    output word_t     flush_target,
    output wire       int_pending
);

    logic [7:0] status_im;
    logic       status_exl;
    logic       status_ie;
    logic       cause_bd;
    logic       cause_ti;
    logic [1:0] cause_ip_sw;  // software interrupt bits
    exc_code_t  cause_exc_code;
    logic [7:0] cause_ip;
    word_t      epc;
    word_t      badvaddr;
    word_t      count;
    word_t      compare;
    logic       tick;         // count runs at half the clock
    word_t      status_word;
    word_t      cause_word;

    wire exc_commit  = ws_valid & ws_ex;
    wire eret_commit = ws_valid & ws_eret & ~ws_ex;
    wire mtc0_we     = ws_valid & ws_mtc0 & ~ws_ex;

    wire addr_err = (ws_exc_code == EXC_ADEL) || (ws_exc_code == EXC_ADES);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= `STATUS_IM_RESET;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (exc_commit) begin
            status_exl <= 1'b1;
        end else if (eret_commit) begin
            status_exl <= 1'b0;
        end else if (mtc0_we && ws_cp0_addr == CP0_STATUS) begin
            status_im  <= ws_result[15:8];
            status_exl <= ws_result[1];
            status_ie  <= ws_result[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd       <= 1'b0;
            cause_ip_sw    <= 2'b00;
            cause_exc_code <= EXC_INT;
        end else if (exc_commit) begin
            if (!status_exl) begin
                cause_bd <= ws_bd;  // BD only follows the first level
            end
            cause_exc_code <= ws_exc_code;
        end else if (mtc0_we && ws_cp0_addr == CP0_CAUSE) begin
            cause_ip_sw <= ws_result[9:8];
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit && !status_exl) begin
            epc <= ws_bd ? ws_pc - INST_BYTES : ws_pc;  // restart at the branch
        end else if (mtc0_we && ws_cp0_addr == CP0_EPC) begin
            epc <= ws_result;
        end
        if (exc_commit && addr_err) begin
            badvaddr <= ws_badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tick     <= 1'b0;
            count    <= `TIMER_RESET;
            compare  <= `TIMER_RESET;
            cause_ti <= 1'b0;
        end else begin
            tick <= ~tick;
            if (mtc0_we && ws_cp0_addr == CP0_COUNT) begin
                count <= ws_result;
            end else if (tick) begin
                count <= count + 1'b1;
            end
            if (mtc0_we && ws_cp0_addr == CP0_COMPARE) begin
                compare  <= ws_result;
                cause_ti <= 1'b0;  // acknowledge timer
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
        end
    end

    // hardware lines on IP[7:2], timer folded in
    always_comb begin
        cause_ip = {ext_int, cause_ip_sw};
        cause_ip[`TIMER_HW_INT] = cause_ip[`TIMER_HW_INT] | cause_ti;
    end

    assign status_word = {9'b0, `STATUS_BEV, 6'b0, status_im, 6'b0, status_exl, status_ie};
    assign cause_word  = {cause_bd, cause_ti, 14'b0, cause_ip, 1'b0, cause_exc_code, 2'b0};

    always_comb begin
        case (ws_cp0_addr)
            CP0_BADVADDR: cp0_rdata = badvaddr;
            CP0_COUNT:    cp0_rdata = count;
            CP0_COMPARE:  cp0_rdata = compare;
            CP0_STATUS:   cp0_rdata = status_word;
            CP0_CAUSE:    cp0_rdata = cause_word;
            CP0_EPC:      cp0_rdata = epc;
            default:      cp0_rdata = '0;
        endcase
    end

    assign flush        = ws_valid & (ws_ex | ws_eret);
    assign flush_target = ws_ex ? `EXC_VECTOR : epc;
    assign int_pending  = status_ie & ~status_exl & |(cause_ip & status_im);

endmodule

`default_nettype wire

/* src/reg_file.sv */
`include "wb_macros.svh"

`default_nettype none

module reg_file
    import pipe_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  wire       we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // $0 is never stored
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read, old value while a write is pending
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* src/cp0_pkg.sv */
`include "wb_macros.svh"

`default_nettype none

package cp0_pkg;

    // {rd, sel} of mfc0/mtc0
    typedef logic [`REG_ADDR_W+2:0] cp0_addr_t;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,  // load or fetch address error
        EXC_ADES = 5'h05,  // store address error
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,  // reserved instruction
        EXC_OV   = 5'h0c
    } exc_code_t;

    localparam cp0_addr_t CP0_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t CP0_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t CP0_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t CP0_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t CP0_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t CP0_EPC      = {5'd14, 3'd0};

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`include "wb_macros.svh"

`default_nettype none

package pipe_pkg;

    // one data or address word
    typedef logic [`WORD_W-1:0] word_t;

    // general register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // pc step used for delay-slot EPC
    localparam word_t INST_BYTES = `WORD_W'd4;

endpackage

`default_nettype wire

/* src/wb_macros.svh */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

`default_nettype none

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32

// general exception entry, BEV=1
`define EXC_VECTOR  32'hbfc0_0380

// Cause.IP bit driven by the Count/Compare timer
`define TIMER_HW_INT 7

// reset values
`define STATUS_BEV  1'b1
`define STATUS_IM_RESET 8'h00
`define TIMER_RESET 32'h0000_0000

`default_nettype wire

`endif
